// ==== all.f ====
logic/repack_cfg_pkg.sv
logic/repack_types_pkg.sv
logic/two_fifo.sv
logic/counter_clear_up.sv
logic/sipo_full_buffered.sv
logic/piso_buffered.sv
logic/serial_repacker.sv
test/serial_repacker_tb.sv

// ==== logic/counter_clear_up.sv ====
module counter_clear_up
  #(parameter  int max_val_p = 3
   ,localparam int width_lp  = (max_val_p > 0) ? $clog2(max_val_p + 1) : 1
  )
  (input  logic                clk_i
  ,input  logic                arst_n_i

  ,input  logic                clear_i
  ,input  logic                up_i
  ,output logic [width_lp-1:0] count_o
  );

  logic [width_lp-1:0] count_r;

  assign count_o = count_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      count_r <= '0;
    else if (clear_i)
      count_r <= '0;             // Clear wins over up.
    else if (up_i)
      count_r <= count_r + 1'b1;
  end

  // The caller must wrap with clear; the counter never rolls over by itself.
  a_no_wrap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (up_i && !clear_i) |-> (count_r != width_lp'(max_val_p)))
    else $error("counter_clear_up: count-up past max_val_p.");

endmodule

// ==== logic/piso_buffered.sv ====
module piso_buffered
  import repack_cfg_pkg::*, repack_types_pkg::*;
  #(parameter int els_p = 2
  )
  (input  logic      clk_i
  ,input  logic      arst_n_i

  ,input  logic      v_i
  ,output logic      ready_o
  ,input  frame_t    data_i

  ,output logic      v_o
  ,input  logic      ready_i
  ,output out_beat_t beat_o
  );

  localparam int lg_els_lp = (els_p > 1) ? $clog2(els_p) : 1;

  if (els_p * out_width_c != in_els_c * in_width_c)
  begin : g_bad_els
    $error("piso_buffered: els_p beats must cover exactly one frame.");
  end

  frame_t               head;
  half_t [els_p-1:0]    halves;
  logic [lg_els_lp-1:0] beat_idx;
  logic                 beat_fire, last_beat;

  two_fifo
    #(.payload_t(frame_t))
    frame_fifo
    (.clk_i   (clk_i)
    ,.arst_n_i(arst_n_i)
    ,.v_i     (v_i)
    ,.ready_o (ready_o)
    ,.data_i  (data_i)
    ,.v_o     (v_o)
    ,.data_o  (head)
    ,.ready_i (beat_fire & last_beat) // Frame leaves with its final beat.
    );

  assign halves    = head;               // Low half is beat 0.
  assign last_beat = (beat_idx == lg_els_lp'(els_p - 1));
  assign beat_fire = v_o & ready_i;

  assign beat_o.data = halves[beat_idx];
  assign beat_o.last = last_beat;

  counter_clear_up
    #(.max_val_p(els_p - 1))
    beat_cnt
    (.clk_i   (clk_i)
    ,.arst_n_i(arst_n_i)
    ,.clear_i (beat_fire & last_beat)
    ,.up_i    (beat_fire & ~last_beat)
    ,.count_o (beat_idx)
    );

  // A stalled beat stays put until it is taken.
  a_beat_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (v_o && !ready_i) |=> (v_o && $stable(beat_o)))
    else $error("piso_buffered: beat changed while stalled.");

endmodule

// ==== logic/repack_cfg_pkg.sv ====
package repack_cfg_pkg;

  // Input side.
  localparam int in_width_c  = 8;  // Bits per input byte.
  localparam int in_els_c    = 4;  // Lanes per assembled frame.

  // Output side.
  localparam int out_width_c = 16; // Bits per output beat.
  localparam int out_els_c   = 2;  // Beats per frame.

endpackage

// ==== logic/repack_types_pkg.sv ====
package repack_types_pkg;
  import repack_cfg_pkg::*;

  typedef logic [in_width_c-1:0] byte_t;   // One input word.

  // Lane 0 sits in the low bits.
  typedef byte_t [in_els_c-1:0] frame_t;

  typedef logic [out_width_c-1:0] half_t;  // One output data word.

  typedef struct packed
  {
    half_t data;  // Halfword payload.
    logic  last;  // Set on the final beat of a frame.
  } out_beat_t;

endpackage

// ==== logic/serial_repacker.sv ====
module serial_repacker
  import repack_cfg_pkg::*, repack_types_pkg::*;
  #(parameter bit hi_to_lo_p = 1'b0
  )
  (input  logic      clk_i
  ,input  logic      arst_n_i

  ,input  logic      in_v_i
  ,output logic      in_ready_o
  ,input  byte_t     in_data_i

  ,output logic      out_v_o
  ,input  logic      out_ready_i
  ,output out_beat_t out_beat_o
  );

  logic   frame_v;
  logic   frame_ready;
  frame_t frame;

  sipo_full_buffered
    #(.els_p     (in_els_c)
     ,.hi_to_lo_p(hi_to_lo_p)
    )
    sipo
    (.clk_i   (clk_i)
    ,.arst_n_i(arst_n_i)
    ,.v_i     (in_v_i)
    ,.ready_o (in_ready_o)
    ,.data_i  (in_data_i)
    ,.v_o     (frame_v)
    ,.ready_i (frame_ready)
    ,.data_o  (frame)
    );

  piso_buffered
    #(.els_p(out_els_c))
    piso
    (.clk_i   (clk_i)
    ,.arst_n_i(arst_n_i)
    ,.v_i     (frame_v)
    ,.ready_o (frame_ready)
    ,.data_i  (frame)
    ,.v_o     (out_v_o)
    ,.ready_i (out_ready_i)
    ,.beat_o  (out_beat_o)
    );

endmodule

// ==== logic/sipo_full_buffered.sv ====
module sipo_full_buffered
  import repack_cfg_pkg::*, repack_types_pkg::*;
  #(parameter int els_p      = 4
   ,parameter bit hi_to_lo_p = 1'b0
  )
  (input  logic   clk_i
  ,input  logic   arst_n_i

  ,input  logic   v_i
  ,output logic   ready_o
  ,input  byte_t  data_i

  ,output logic   v_o
  ,input  logic   ready_i
  ,output frame_t data_o
  );

  localparam int lg_els_lp = (els_p > 1) ? $clog2(els_p) : 1;

  if (els_p != in_els_c)
  begin : g_bad_els
    $error("sipo_full_buffered: els_p must equal the frame lane count.");
  end

  logic [lg_els_lp-1:0] lane_idx;
  logic [els_p-1:0]     lane_v_li, lane_ready_lo, lane_v_lo;
  byte_t [els_p-1:0]    lane_data;
  byte_t [els_p-1:0]    lane_ordered;
  logic                 in_fire, frame_pop;
  logic                 last_lane;

  assign ready_o   = lane_ready_lo[lane_idx]; // Only the selected lane matters.
  assign in_fire   = v_i & ready_o;
  assign last_lane = (lane_idx == lg_els_lp'(els_p - 1));

  assign v_o       = &lane_v_lo;              // Frame ready once every lane holds a byte.
  assign frame_pop = v_o & ready_i;

  for (genvar i = 0; i < els_p; i++)
  begin : g_lane
    assign lane_v_li[i] = v_i & (lane_idx == lg_els_lp'(i)); // One-hot steering.

    two_fifo
      #(.payload_t(byte_t))
      fifo
      (.clk_i   (clk_i)
      ,.arst_n_i(arst_n_i)
      ,.v_i     (lane_v_li[i])
      ,.ready_o (lane_ready_lo[i])
      ,.data_i  (data_i)
      ,.v_o     (lane_v_lo[i])
      ,.data_o  (lane_data[i])
      ,.ready_i (frame_pop)     // All lanes pop together.
      );

    if (hi_to_lo_p)
    begin : g_rev
      assign lane_ordered[i] = lane_data[els_p-1-i];
    end
    else
    begin : g_fwd
      assign lane_ordered[i] = lane_data[i];
    end
  end

  assign data_o = lane_ordered;

  counter_clear_up
    #(.max_val_p(els_p - 1))
    lane_cnt
    (.clk_i   (clk_i)
    ,.arst_n_i(arst_n_i)
    ,.clear_i (in_fire & last_lane)
    ,.up_i    (in_fire & ~last_lane)
    ,.count_o (lane_idx)
    );

endmodule

// ==== logic/two_fifo.sv ====
module two_fifo
  #(parameter type payload_t = logic
  )
  (input  logic     clk_i
  ,input  logic     arst_n_i

  ,input  logic     v_i
  ,output logic     ready_o
  ,input  payload_t data_i

  ,output logic     v_o
  ,output payload_t data_o
  ,input  logic     ready_i
  );

  payload_t mem_r [2];
  logic     wr_ptr_r, rd_ptr_r;
  logic     full_r, empty_r;
  logic     enq, deq;

  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];
  assign ready_o = ~full_r | ready_i;  // A full FIFO still takes a write on a read.

  assign enq = v_i & ready_o;
  assign deq = v_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      if (enq & ~deq)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wr_ptr_r == rd_ptr_r); // Second entry lands.
      end
      else if (deq & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rd_ptr_r == wr_ptr_r); // Last entry leaves.
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

  // A held head entry is never overwritten while it waits to be read.
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (v_o && !ready_i) |=> (v_o && $stable(data_o)))
    else $error("two_fifo: head entry overwritten without a read.");

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds and runs the repacker testbench once per lane order.
set -e
cd "$(dirname "$0")"

status=0
for rev in 0 1
do
  verilator --binary --timing --assert -f all.f --top-module serial_repacker_tb \
    -Ghi_to_lo_p=$rev --Mdir build/rev$rev -o sim
  ./build/rev$rev/sim > build/sim_rev$rev.log 2>&1 || true
  cat build/sim_rev$rev.log
  if grep -q "=== FAIL ===" build/sim_rev$rev.log || ! grep -q "=== PASS ===" build/sim_rev$rev.log
  then
    echo "hi_to_lo_p=$rev: simulation failed"
    status=1
  fi
done
exit $status

// ==== test/serial_repacker_tb.sv ====
module serial_repacker_tb
  import repack_cfg_pkg::*, repack_types_pkg::*;
  #(parameter bit hi_to_lo_p = 1'b0
  )
  ();

  localparam int frames_c = 10;

  typedef struct packed
  {
    logic [31:0] bytes;    // Byte 0 in the low bits.
    logic        gap;      // Random idle cycles before each byte.
    logic        stall;    // Random low out_ready_i on this frame's beats.
    logic [31:0] exp_fwd;  // {beat 1, beat 0} with hi_to_lo_p at 0.
    logic [31:0] exp_rev;  // {beat 1, beat 0} with hi_to_lo_p at 1.
  } frame_row_t;

  frame_row_t stim [frames_c] = '{
    '{32'h44332211, 1'b0, 1'b0, 32'h44332211, 32'h11223344},
    '{32'h88776655, 1'b0, 1'b0, 32'h88776655, 32'h55667788},
    '{32'hccbbaa99, 1'b0, 1'b0, 32'hccbbaa99, 32'h99aabbcc},
    '{32'h00ffeedd, 1'b1, 1'b0, 32'h00ffeedd, 32'hddeeff00},
    '{32'h13579bdf, 1'b1, 1'b0, 32'h13579bdf, 32'hdf9b5713},
    '{32'h2468ace0, 1'b0, 1'b1, 32'h2468ace0, 32'he0ac6824},
    '{32'hdeadbeef, 1'b0, 1'b1, 32'hdeadbeef, 32'hefbeadde},
    '{32'h0f1e2d3c, 1'b1, 1'b1, 32'h0f1e2d3c, 32'h3c2d1e0f},
    '{32'ha5a55a5a, 1'b1, 1'b1, 32'ha5a55a5a, 32'h5a5aa5a5},
    '{32'h01020304, 1'b0, 1'b0, 32'h01020304, 32'h04030201}
  };

  logic      clk_i;
  logic      arst_n_i;
  logic      in_v_i;
  logic      in_ready_o;
  byte_t     in_data_i;
  logic      out_v_o;
  logic      out_ready_i;
  out_beat_t out_beat_o;

  int        gap_seed   = 32'h7eb1_1a1e;
  int        stall_seed = 32'h7eb1_1a1e;
  out_beat_t exp_q [$];   // Beats still owed by the DUT, oldest first.
  int        beats_seen;

  serial_repacker
    #(.hi_to_lo_p(hi_to_lo_p))
    dut0
    (.clk_i      (clk_i)
    ,.arst_n_i   (arst_n_i)
    ,.in_v_i     (in_v_i)
    ,.in_ready_o (in_ready_o)
    ,.in_data_i  (in_data_i)
    ,.out_v_o    (out_v_o)
    ,.out_ready_i(out_ready_i)
    ,.out_beat_o (out_beat_o)
    );

  always #50 clk_i = ~clk_i;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Stopping at the first error.");
    end
  endtask

  // Holds one byte on the input until the DUT takes it.
  task automatic send_byte(input byte_t b, input logic gap);
    int   gap_cycles;
    logic taken;
    gap_cycles = 0;
    taken      = 1'b0;
    @(negedge clk_i);
    if (gap)
      gap_cycles = $unsigned($random(gap_seed)) % 3;
    in_v_i = 1'b0;
    repeat (gap_cycles) @(negedge clk_i);
    in_v_i    = 1'b1;
    in_data_i = b;
    while (!taken)
    begin
      #25;                  // Mid low phase, all inputs settled.
      taken = in_ready_o;
      if (!taken)
        @(negedge clk_i);
    end
  endtask

  task automatic drive_frames();
    logic [31:0] exp_word;
    out_beat_t   beat;
    for (int f = 0; f < frames_c; f++)
    begin
      exp_word  = hi_to_lo_p ? stim[f].exp_rev : stim[f].exp_fwd;
      beat.data = exp_word[15:0];
      beat.last = 1'b0;
      exp_q.push_back(beat);
      beat.data = exp_word[31:16];
      beat.last = 1'b1;
      exp_q.push_back(beat);
      for (int i = 0; i < in_els_c; i++)
        send_byte(byte_t'(stim[f].bytes >> (in_width_c * i)), stim[f].gap);
    end
    @(negedge clk_i);
    in_v_i = 1'b0;
  endtask

  // Takes beats with optional random back-pressure and checks each one.
  task automatic collect_beats();
    logic      held;
    out_beat_t held_beat;
    out_beat_t exp;
    held      = 1'b0;
    held_beat = '0;
    while (beats_seen < 2 * frames_c)
    begin
      @(negedge clk_i);
      if (stim[beats_seen / 2].stall)
        out_ready_i = 1'($random(stall_seed));
      else
        out_ready_i = 1'b1;
      #25;
      if (held)
      begin
        check_value(32'(out_v_o), 32'd1, "out_v_o dropped while stalled");
        check_value(32'(out_beat_o), 32'(held_beat), "beat changed while stalled");
      end
      held = 1'b0;
      if (out_v_o && out_ready_i)
      begin
        check_value(32'(exp_q.size() != 0), 32'd1, "beat with nothing expected");
        exp = exp_q.pop_front();
        check_value(32'(out_beat_o), 32'(exp), "output beat {data, last}");
        beats_seen++;
      end
      else if (out_v_o)
      begin
        held      = 1'b1;
        held_beat = out_beat_o;
      end
    end
  endtask

  initial
  begin
    repeat (frames_c * 40) @(posedge clk_i);
    $display("Timeout: the stream did not finish within %0d clock cycles.", frames_c * 40);
    $display("=== FAIL ===");
    $fatal(1, "Watchdog expired.");
  end

  initial
  begin
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    in_v_i      = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    beats_seen  = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #25;
    check_value(32'(out_v_o), 32'd0, "out_v_o after reset");
    check_value(32'(in_ready_o), 32'd1, "in_ready_o after reset");

    fork
      drive_frames();
      collect_beats();
    join

    // No stray beats once the stream is done.
    repeat (4)
    begin
      @(negedge clk_i);
      out_ready_i = 1'b1;
      #25;
      check_value(32'(out_v_o), 32'd0, "out_v_o after the last frame");
    end
    check_value(32'(in_ready_o), 32'd1, "in_ready_o after the last frame");

    $display("=== PASS ===");
    $finish;
  end

endmodule
